// File: include/ptw_settings.svh
// ptw settings: address widths and field sizes for the three-level page table walker
`ifndef PTW_SETTINGS_SVH
`define PTW_SETTINGS_SVH

// ====================
// address scheme
// ====================
// 39-bit virtual, 40-bit physical, 4 KB base page
`define PTW_VPN_W     27
`define PTW_PPN_W     28
`define PTW_PADDR_W   40

// vpn bits consumed per table level
`define PTW_LVL_BITS  9

// ====================
// pte and refill fields
// ====================
`define PTW_PTE_W     64
`define PTW_FLG_W     14
`define PTW_ASID_W    16

// bank field, three 4-bit selects
// one per page size, 4 KB in the low nibble
`define PTW_BANK_W    12

`endif

// File: src/ptw_pkg.sv
// ptw package: request, memory response, pte views and refill entry types
`include "ptw_settings.svh"

package ptw_pkg;

  // access type encodings from the requester
  typedef enum logic [2:0] {
    ACC_LOAD  = 3'b010,
    ACC_FETCH = 3'b011,
    ACC_PREF  = 3'b100,
    ACC_STORE = 3'b110
  } access_type_e;

  typedef struct packed {
    logic                   valid;
    logic [`PTW_VPN_W-1:0]  vpn;
    logic [`PTW_BANK_W-1:0] bank;
    access_type_e           acc;
  } walk_req_t;

  typedef struct packed {
    logic                  valid;
    logic                  err;
    logic [`PTW_PTE_W-1:0] data;
  } mem_rsp_t;

  // ====================
  // pte word
  // ====================
  // hg is H at levels 1 and 2, G at level 3
  typedef struct packed {
    logic [2:0]            attr;
    logic [20:0]           rsv_hi;
    logic [`PTW_PPN_W-1:0] ppn;
    logic [2:0]            rsv_lo;
    logic                  w;
    logic                  p;
    logic                  hg;
    logic [4:0]            low;
    logic                  v;
  } pte_base_t;

  // huge pages reuse ppn bit 0 as global
  typedef struct packed {
    logic [2:0]  attr;
    logic [20:0] rsv_hi;
    logic [9:0]  ppn_hi;
    logic [8:0]  align_1g;
    logic [7:0]  align_2m;
    logic        g;
    logic [11:0] low;
  } pte_huge_t;

  typedef union packed {
    pte_base_t base;
    pte_huge_t huge;
  } pte_u;

  // one-hot, 1 GB in the msb
  typedef struct packed {
    logic sz_1g;
    logic sz_2m;
    logic sz_4k;
  } page_size_t;

  typedef enum logic [1:0] {
    LVL_NONE   = 2'd0,
    LVL_FIRST  = 2'd1,
    LVL_SECOND = 2'd2,
    LVL_THIRD  = 2'd3
  } walk_level_e;

  typedef struct packed {
    logic complete;
    logic acc_flt;
    logic pg_flt;
  } walk_status_t;

  typedef struct packed {
    logic [`PTW_VPN_W-1:0]  vpn;
    logic [`PTW_PPN_W-1:0]  ppn;
    logic [`PTW_FLG_W-1:0]  flg;
    page_size_t             pgs;
    logic                   g;
    logic [`PTW_ASID_W-1:0] asid;
    logic [3:0]             bank_sel;
  } refill_t;

endpackage

// File: src/ptw_walk_ctrl.sv
// ptw walk control: walk state machine, request register and status generation
`timescale 1ns/100ps

module ptw_walk_ctrl (
  input  logic                  ptw_clk,
  input  logic                  cpurst_b,
  input  ptw_pkg::walk_req_t    walk_req,
  input  ptw_pkg::mem_rsp_t     mem_rsp,
  input  logic                  leaf_hit,
  input  logic                  huge_hit,
  input  logic                  page_fault,
  input  logic                  refill_grant,
  output logic                  walk_busy,
  output logic                  mem_req,
  output logic                  addr_first,
  output ptw_pkg::walk_level_e  chk_level,
  output logic                  leaf_take,
  output ptw_pkg::walk_req_t    held_req,
  output logic                  refill_req,
  output ptw_pkg::walk_status_t status
);
  import ptw_pkg::*;

  typedef enum logic [3:0] {
    ST_IDLE, ST_FST_DATA, ST_FST_CHK, ST_SCD_DATA, ST_SCD_CHK,
    ST_THD_DATA, ST_THD_CHK, ST_ACC_FLT, ST_PGE_FLT, ST_DATA_VLD
  } walk_st_e;

  walk_st_e cur_st;
  walk_st_e nxt_st;
  logic     in_chk;

  // ====================
  // walk fsm
  // ====================
  always_ff @(posedge ptw_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cur_st <= ST_IDLE;
    else
      cur_st <= nxt_st;
  end

  always_comb
  begin
    nxt_st = cur_st;
    case (cur_st)
      ST_IDLE:
        if (walk_req.valid)
          nxt_st = ST_FST_DATA;
      ST_FST_DATA, ST_SCD_DATA, ST_THD_DATA:
      begin
        // bus error wins over data
        if (mem_rsp.err)
          nxt_st = ST_ACC_FLT;
        else if (mem_rsp.valid)
          nxt_st = walk_st_e'(cur_st + 4'd1);
      end
      ST_FST_CHK:
        if (page_fault)
          nxt_st = ST_PGE_FLT;
        else if (huge_hit)
          nxt_st = ST_DATA_VLD;
        else
          nxt_st = ST_SCD_DATA;
      ST_SCD_CHK:
        if (page_fault)
          nxt_st = ST_PGE_FLT;
        else if (huge_hit)
          nxt_st = ST_DATA_VLD;
        else
          nxt_st = ST_THD_DATA;
      ST_THD_CHK:
        if (page_fault)
          nxt_st = ST_PGE_FLT;
        else if (leaf_hit)
          nxt_st = ST_DATA_VLD;
      ST_ACC_FLT, ST_PGE_FLT:
        nxt_st = ST_IDLE;
      ST_DATA_VLD:
        if (refill_grant)
          nxt_st = ST_IDLE;
      default:
        nxt_st = ST_IDLE;
    endcase
  end

  // level of the pte being fetched or checked
  always_comb
  begin
    case (cur_st)
      ST_FST_DATA, ST_FST_CHK: chk_level = LVL_FIRST;
      ST_SCD_DATA, ST_SCD_CHK: chk_level = LVL_SECOND;
      ST_THD_DATA, ST_THD_CHK: chk_level = LVL_THIRD;
      default:                 chk_level = LVL_NONE;
    endcase
  end

  // request held for the whole walk
  always_ff @(posedge ptw_clk)
  begin
    if (addr_first)
      held_req <= walk_req;
  end

  assign in_chk     = (cur_st == ST_FST_CHK) || (cur_st == ST_SCD_CHK) || (cur_st == ST_THD_CHK);
  assign addr_first = (cur_st == ST_IDLE) && walk_req.valid;
  assign leaf_take  = in_chk && leaf_hit && !page_fault;
  assign walk_busy  = (cur_st != ST_IDLE);
  assign mem_req    = (cur_st == ST_FST_DATA) || (cur_st == ST_SCD_DATA)
                   || (cur_st == ST_THD_DATA);
  assign refill_req = (cur_st == ST_DATA_VLD);

  // ====================
  // walk status
  // ====================
  assign status.acc_flt  = (cur_st == ST_ACC_FLT);
  assign status.pg_flt   = (cur_st == ST_PGE_FLT);
  assign status.complete = status.acc_flt || status.pg_flt || (refill_req && refill_grant);

endmodule

// File: src/ptw_addr_gen.sv
// ptw address generation: per-level pte address and the register driving memory
`timescale 1ns/100ps
`include "ptw_settings.svh"

module ptw_addr_gen (
  input  logic                      ptw_clk,
  input  logic                      cpurst_b,
  input  ptw_pkg::walk_req_t        walk_req,
  input  ptw_pkg::walk_req_t        held_req,
  input  logic                      addr_first,
  input  ptw_pkg::walk_level_e      chk_level,
  input  ptw_pkg::mem_rsp_t         mem_rsp,
  input  logic [`PTW_PPN_W-1:0]     satp_ppn,
  output logic [`PTW_PADDR_W-1:0]   mem_addr
);
  import ptw_pkg::*;

  pte_u                    rsp_pte;
  logic [`PTW_PADDR_W-1:0] addr_nxt;

  assign rsp_pte = mem_rsp.data;

  // pte address is table base plus vpn slice times eight
  always_comb
  begin
    addr_nxt = mem_addr;
    if (addr_first)
      addr_nxt = {satp_ppn, walk_req.vpn[`PTW_VPN_W-1:2*`PTW_LVL_BITS], 3'b000};
    else if (mem_rsp.valid)
    begin
      case (chk_level)
        LVL_FIRST:
          addr_nxt = {rsp_pte.base.ppn,
                      held_req.vpn[2*`PTW_LVL_BITS-1:`PTW_LVL_BITS], 3'b000};
        LVL_SECOND:
          addr_nxt = {rsp_pte.base.ppn, held_req.vpn[`PTW_LVL_BITS-1:0], 3'b000};
        // third level fetches nothing more
        default:
          addr_nxt = mem_addr;
      endcase
    end
  end

  always_ff @(posedge ptw_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      mem_addr <= '0;
    else if (addr_first || mem_rsp.valid)
      mem_addr <= addr_nxt;
  end

endmodule

// File: src/ptw_pte_check.sv
// ptw pte check: pte capture, huge leaf detection and page fault decision
`timescale 1ns/100ps

module ptw_pte_check (
  input  logic                 ptw_clk,
  input  logic                 cpurst_b,
  input  ptw_pkg::mem_rsp_t    mem_rsp,
  input  ptw_pkg::walk_level_e chk_level,
  input  ptw_pkg::walk_req_t   held_req,
  output ptw_pkg::pte_u        pte,
  output logic                 huge_hit,
  output logic                 leaf_hit,
  output logic                 page_fault
);
  import ptw_pkg::*;

  logic pte_usable;
  logic hit_1g;
  logic hit_2m;
  logic is_store;
  logic is_fetch;
  logic misalign;

  // latched on the response cycle, used in the check cycle
  always_ff @(posedge ptw_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      pte <= '0;
    else if (mem_rsp.valid)
      pte <= mem_rsp.data;
  end

  // ====================
  // leaf detection
  // ====================
  assign pte_usable = pte.base.p && pte.base.v;
  assign hit_1g     = (chk_level == LVL_FIRST) && pte.base.hg && pte_usable;
  assign hit_2m     = (chk_level == LVL_SECOND) && pte.base.hg && pte_usable;
  assign huge_hit   = hit_1g || hit_2m;
  assign leaf_hit   = huge_hit || (chk_level == LVL_THIRD);

  // ====================
  // page fault
  // ====================
  assign is_store = (held_req.acc == ACC_STORE);
  assign is_fetch = (held_req.acc == ACC_FETCH);

  // huge ppn must be aligned to its page size
  assign misalign = hit_1g && (|{pte.huge.align_1g, pte.huge.align_2m})
                 || hit_2m && (|pte.huge.align_2m);

  // nx is attribute bit 62
  assign page_fault = leaf_hit && (   !pte.base.v
                                   || is_store && !pte.base.w
                                   || is_fetch && pte.base.attr[1]
                                   || misalign);

endmodule

// File: src/ptw_refill_build.sv
// ptw refill builder that captures the leaf pte and assembles the refill entry
`timescale 1ns/100ps
`include "ptw_settings.svh"

module ptw_refill_build (
  input  logic                     ptw_clk,
  input  logic                     cpurst_b,
  input  logic                     leaf_take,
  input  ptw_pkg::walk_level_e     chk_level,
  input  ptw_pkg::pte_u            pte,
  input  ptw_pkg::walk_req_t       held_req,
  input  logic [`PTW_ASID_W-1:0]   cur_asid,
  output ptw_pkg::refill_t         refill
);
  import ptw_pkg::*;

  page_size_t pgs_q;
  logic       ppn0_q;
  logic       g_q;

  // ====================
  // leaf capture
  // ====================
  always_ff @(posedge ptw_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      pgs_q  <= '0;
      ppn0_q <= 1'b0;
      g_q    <= 1'b0;
    end
    else if (leaf_take)
    begin
      pgs_q.sz_1g <= (chk_level == LVL_FIRST);
      pgs_q.sz_2m <= (chk_level == LVL_SECOND);
      pgs_q.sz_4k <= (chk_level == LVL_THIRD);
      // bit 12 is g on huge pages
      ppn0_q      <= (chk_level == LVL_THIRD) ? pte.base.ppn[0] : 1'b0;
      g_q         <= (chk_level == LVL_THIRD) ? pte.base.hg : pte.huge.g;
    end
  end

  // ====================
  // entry assembly
  // ====================
  // vpn cleared below the page size
  assign refill.vpn = {`PTW_VPN_W{pgs_q.sz_1g}} & {held_req.vpn[26:18], 18'b0}
                    | {`PTW_VPN_W{pgs_q.sz_2m}} & {held_req.vpn[26:9], 9'b0}
                    | {`PTW_VPN_W{pgs_q.sz_4k}} & held_req.vpn;

  assign refill.ppn  = {pte.base.ppn[`PTW_PPN_W-1:1], ppn0_q};
  // top flag bit is spare
  assign refill.flg  = {1'b0, pte.base.attr, pte.huge.g, pte.huge.low[8:0]};
  assign refill.pgs  = pgs_q;
  assign refill.g    = g_q;
  assign refill.asid = cur_asid;

  assign refill.bank_sel = {4{pgs_q.sz_4k}} & held_req.bank[3:0]
                         | {4{pgs_q.sz_2m}} & held_req.bank[7:4]
                         | {4{pgs_q.sz_1g}} & held_req.bank[11:8];

endmodule

// File: src/ptw_top.sv
// ptw top: three-level page table walker built from control, address, check and refill blocks
`timescale 1ns/100ps
`include "ptw_settings.svh"

module ptw_top (
  input  logic                      ptw_clk,
  input  logic                      cpurst_b,
  input  ptw_pkg::walk_req_t        walk_req,
  input  ptw_pkg::mem_rsp_t         mem_rsp,
  input  logic                      refill_grant,
  input  logic [`PTW_PPN_W-1:0]     satp_ppn,
  input  logic [`PTW_ASID_W-1:0]    cur_asid,
  output logic                      walk_busy,
  output logic                      mem_req,
  output logic [`PTW_PADDR_W-1:0]   mem_addr,
  output logic                      refill_req,
  output ptw_pkg::refill_t          refill,
  output ptw_pkg::walk_status_t     status
);
  import ptw_pkg::*;

  logic        addr_first;
  logic        leaf_take;
  logic        leaf_hit;
  logic        huge_hit;
  logic        page_fault;
  walk_level_e chk_level;
  walk_req_t   held_req;
  pte_u        pte;

  ptw_walk_ctrl ptw_walk_ctrl_i (
    .ptw_clk      (ptw_clk),
    .cpurst_b     (cpurst_b),
    .walk_req     (walk_req),
    .mem_rsp      (mem_rsp),
    .leaf_hit     (leaf_hit),
    .huge_hit     (huge_hit),
    .page_fault   (page_fault),
    .refill_grant (refill_grant),
    .walk_busy    (walk_busy),
    .mem_req      (mem_req),
    .addr_first   (addr_first),
    .chk_level    (chk_level),
    .leaf_take    (leaf_take),
    .held_req     (held_req),
    .refill_req   (refill_req),
    .status       (status)
  );

  ptw_addr_gen ptw_addr_gen_i (
    .ptw_clk    (ptw_clk),
    .cpurst_b   (cpurst_b),
    .walk_req   (walk_req),
    .held_req   (held_req),
    .addr_first (addr_first),
    .chk_level  (chk_level),
    .mem_rsp    (mem_rsp),
    .satp_ppn   (satp_ppn),
    .mem_addr   (mem_addr)
  );

  ptw_pte_check ptw_pte_check_i (
    .ptw_clk    (ptw_clk),
    .cpurst_b   (cpurst_b),
    .mem_rsp    (mem_rsp),
    .chk_level  (chk_level),
    .held_req   (held_req),
    .pte        (pte),
    .huge_hit   (huge_hit),
    .leaf_hit   (leaf_hit),
    .page_fault (page_fault)
  );

  ptw_refill_build ptw_refill_build_i (
    .ptw_clk   (ptw_clk),
    .cpurst_b  (cpurst_b),
    .leaf_take (leaf_take),
    .chk_level (chk_level),
    .pte       (pte),
    .held_req  (held_req),
    .cur_asid  (cur_asid),
    .refill    (refill)
  );

endmodule

// File: verification/ptw_mem_model.sv
// ptw memory model: page table store with random response delay and bus error injection
`timescale 1ns/100ps
`include "ptw_settings.svh"

module ptw_mem_model (
  input  logic                               ptw_clk,
  input  logic                               cpurst_b,
  input  logic                               mem_req,
  input  logic [`PTW_PADDR_W-1:0]            mem_addr,
  input  logic                               tbl_load,
  input  logic [2:0][`PTW_PADDR_W-1:0]       tbl_addr,
  input  logic [2:0][`PTW_PTE_W-1:0]         tbl_data,
  input  logic [1:0]                         err_lvl,
  output ptw_pkg::mem_rsp_t                  mem_rsp,
  output logic [2:0][`PTW_PADDR_W-1:0]       cap_addr,
  output logic [1:0]                         cap_cnt
);
  import ptw_pkg::*;

  logic [31:0]             rng;
  logic                    pend;
  logic                    clr;
  logic [1:0]              wait_cnt;
  logic [`PTW_PADDR_W-1:0] req_addr;
  int                      hit;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  initial
  begin
    mem_rsp  = '0;
    rng      = 32'd8;
    pend     = 1'b0;
    wait_cnt = 2'd0;
    req_addr = '0;
    cap_addr = '0;
    cap_cnt  = 2'd0;
  end

  // ====================
  // request and response
  // ====================
  always @(posedge ptw_clk)
  begin
    // table load and reset are sampled on the edge itself
    clr = !cpurst_b || tbl_load;
    #1;
    if (clr)
    begin
      mem_rsp  = '0;
      pend     = 1'b0;
      cap_addr = '0;
      cap_cnt  = 2'd0;
    end
    else if (mem_rsp.valid || mem_rsp.err)
      mem_rsp = '0;
    else if (pend)
    begin
      if (wait_cnt != 2'd0)
        wait_cnt = wait_cnt - 2'd1;
      else
      begin
        // lowest matching table slot wins
        hit = -1;
        for (int i = 2; i >= 0; i--)
          if (tbl_addr[i] == req_addr)
            hit = i;
        // unmapped address also answers with a bus error
        if (hit < 0 || int'(err_lvl) == hit + 1)
          mem_rsp.err = 1'b1;
        else
        begin
          mem_rsp.valid = 1'b1;
          mem_rsp.data  = tbl_data[hit];
        end
        pend = 1'b0;
      end
    end
    else if (mem_req)
    begin
      req_addr = mem_addr;
      if (cap_cnt < 2'd3)
      begin
        cap_addr[cap_cnt] = mem_addr;
        cap_cnt = cap_cnt + 2'd1;
      end
      rng      = xorshift32(rng);
      wait_cnt = rng[1:0];
      pend     = 1'b1;
    end
  end

endmodule

// File: verification/ptw_tb.sv
// table-driven testbench that runs page table walks against a memory model
`timescale 1ns/100ps
`include "ptw_settings.svh"

module ptw_tb;
  import ptw_pkg::*;

  localparam logic [8:0]             F_V  = 9'h001;
  localparam logic [8:0]             F_H  = 9'h040;
  localparam logic [8:0]             F_P  = 9'h080;
  localparam logic [8:0]             F_W  = 9'h100;
  localparam logic [`PTW_BANK_W-1:0] BANK = 12'h7b3;
  localparam logic [`PTW_ASID_W-1:0] ASID = 16'h5a3c;

  typedef struct packed {
    logic [`PTW_VPN_W-1:0]        vpn;
    access_type_e                 acc;
    logic [`PTW_PPN_W-1:0]        satp;
    logic [2:0][`PTW_PTE_W-1:0]   pte;
    logic [1:0]                   err_lvl;
    logic [3:0]                   gnt_dly;
    walk_status_t                 exp_st;
  } row_t;

  row_t  rows[$];
  string names[$];

  logic                           ptw_clk;
  logic                           cpurst_b;
  walk_req_t                      walk_req;
  mem_rsp_t                       mem_rsp;
  logic                           refill_grant;
  logic [`PTW_PPN_W-1:0]          satp_ppn;
  logic [`PTW_ASID_W-1:0]         cur_asid;
  logic                           walk_busy;
  logic                           mem_req;
  logic [`PTW_PADDR_W-1:0]        mem_addr;
  logic                           refill_req;
  refill_t                        refill;
  walk_status_t                   status;
  logic                           tbl_load;
  logic [2:0][`PTW_PADDR_W-1:0]   tbl_addr;
  logic [2:0][`PTW_PTE_W-1:0]     tbl_data;
  logic [1:0]                     err_lvl;
  logic [2:0][`PTW_PADDR_W-1:0]   cap_addr;
  logic [1:0]                     cap_cnt;

  int errors      = 0;
  int passed      = 0;
  int failed      = 0;
  int cycle_cnt   = 0;
  int cycle_limit = 1000;

  ptw_top ptw_top_i (
    .ptw_clk      (ptw_clk),
    .cpurst_b     (cpurst_b),
    .walk_req     (walk_req),
    .mem_rsp      (mem_rsp),
    .refill_grant (refill_grant),
    .satp_ppn     (satp_ppn),
    .cur_asid     (cur_asid),
    .walk_busy    (walk_busy),
    .mem_req      (mem_req),
    .mem_addr     (mem_addr),
    .refill_req   (refill_req),
    .refill       (refill),
    .status       (status)
  );

  ptw_mem_model mem_model_i (
    .ptw_clk  (ptw_clk),
    .cpurst_b (cpurst_b),
    .mem_req  (mem_req),
    .mem_addr (mem_addr),
    .tbl_load (tbl_load),
    .tbl_addr (tbl_addr),
    .tbl_data (tbl_data),
    .err_lvl  (err_lvl),
    .mem_rsp  (mem_rsp),
    .cap_addr (cap_addr),
    .cap_cnt  (cap_cnt)
  );

  always #2 ptw_clk = ~ptw_clk;

  always @(posedge ptw_clk)
  begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit)
    begin
      $display("timeout: walks did not finish within %0d cycles", cycle_limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ====================
  // compare tasks
  // ====================
  task automatic check_status(input string name, input walk_status_t exp,
                              input walk_status_t act);
    if (act !== exp)
    begin
      $display("Mismatch %s status expected %b actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_refill(input string name, input refill_t exp, input refill_t act);
    if (act !== exp)
    begin
      $display("Mismatch %s refill expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_addr(input string name, input logic [`PTW_PADDR_W-1:0] exp,
                            input logic [`PTW_PADDR_W-1:0] act);
    if (act !== exp)
    begin
      $display("Mismatch %s address expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  function automatic logic [63:0] make_pte(input logic [2:0] attr, input logic [27:0] ppn,
                                           input logic [8:0] flg);
    return {attr, 21'b0, ppn, 3'b0, flg};
  endfunction

  // ====================
  // stimulus table
  // ====================
  // flt selects refill (0), access fault (1) or page fault (2)
  task automatic add_row(input string name, input logic [26:0] vpn, input access_type_e acc,
                         input logic [27:0] satp, input logic [63:0] p1,
                         input logic [63:0] p2, input logic [63:0] p3,
                         input logic [1:0] err, input logic [3:0] gnt, input int flt);
    row_t r;
    r.vpn     = vpn;
    r.acc     = acc;
    r.satp    = satp;
    r.pte     = {p3, p2, p1};
    r.err_lvl = err;
    r.gnt_dly = gnt;
    r.exp_st  = '{complete: 1'b1, acc_flt: flt == 1, pg_flt: flt == 2};
    rows.push_back(r);
    names.push_back(name);
  endtask

  task automatic build_table();
    logic [63:0] ptr_a;
    logic [63:0] ptr_b;
    logic [63:0] leaf;
    ptr_a = make_pte(3'b000, 28'h0080020, F_P | F_V);
    ptr_b = make_pte(3'b000, 28'h0080030, F_P | F_V);
    leaf  = make_pte(3'b101, 28'h0123457, F_W | F_P | F_H | F_V | 9'h026);
    add_row("walk_4k", 27'h4d29c71, ACC_LOAD, 28'h0080010, ptr_a, ptr_b, leaf, 0, 0, 0);
    add_row("leaf_1g", 27'h3fe1234, ACC_FETCH, 28'h0080110,
            make_pte(3'b001, 28'h0a40001, F_P | F_H | F_V), 0, 0, 0, 1, 0);
    add_row("leaf_2m", 27'h1c05a5b, ACC_STORE, 28'h0080210, ptr_a,
            make_pte(3'b100, 28'h0123601, F_W | F_P | F_H | F_V), 0, 0, 2, 0);
    add_row("buserr_l1", 27'h0123456, ACC_LOAD, 28'h0080310, ptr_a, ptr_b, leaf, 1, 0, 1);
    add_row("buserr_l2", 27'h0123456, ACC_LOAD, 28'h0080410, ptr_a, ptr_b, leaf, 2, 0, 1);
    add_row("buserr_l3", 27'h0123456, ACC_LOAD, 28'h0080510, ptr_a, ptr_b, leaf, 3, 0, 1);
    add_row("pf_invalid", 27'h2468ace, ACC_LOAD, 28'h0080610, ptr_a, ptr_b,
            make_pte(3'b000, 28'h0234567, F_W | F_P), 0, 0, 2);
    add_row("pf_store_ro", 27'h2468ace, ACC_STORE, 28'h0080710, ptr_a, ptr_b,
            make_pte(3'b000, 28'h0234567, F_P | F_V), 0, 0, 2);
    add_row("pf_fetch_nx", 27'h13579bd, ACC_FETCH, 28'h0080810, ptr_a, ptr_b,
            make_pte(3'b010, 28'h0234567, F_W | F_P | F_V), 0, 0, 2);
    add_row("pf_1g_misalign", 27'h3fe1234, ACC_LOAD, 28'h0080910,
            make_pte(3'b000, 28'h0a40100, F_P | F_H | F_V), 0, 0, 0, 0, 2);
    add_row("walk_4k_slow_grant", 27'h7654321, ACC_PREF, 28'h0080a10, ptr_a, ptr_b,
            make_pte(3'b011, 28'h0fedcba, F_P | F_V | 9'h01e), 0, 6, 0);
    add_row("leaf_2m_slow_grant", 27'h0abcdef, ACC_LOAD, 28'h0080b10, ptr_b,
            make_pte(3'b000, 28'h0345a00, F_P | F_H | F_V), 0, 0, 4, 0);
  endtask

  // expected reads and refill entry from the address and leaf rules
  task automatic predict_walk(input row_t r, output logic [2:0][`PTW_PADDR_W-1:0] addr,
                              output int n_fetch, output refill_t ref_e);
    logic [`PTW_PPN_W-1:0] base;
    logic [`PTW_VPN_W-1:0] keep_mask;
    logic [63:0]           p;
    logic                  stop;
    int                    leaf_lvl;
    base     = r.satp;
    stop     = 1'b0;
    leaf_lvl = 0;
    n_fetch  = 0;
    ref_e    = '0;
    for (int lvl = 1; lvl <= 3; lvl++)
    begin
      p = r.pte[lvl-1];
      addr[lvl-1] = {base, r.vpn[(3-lvl)*9 +: 9], 3'b000};
      if (!stop)
      begin
        n_fetch = lvl;
        if (int'(r.err_lvl) == lvl)
          stop = 1'b1;
        else if (lvl == 3 || p[6] && p[7] && p[0])
        begin
          stop     = 1'b1;
          leaf_lvl = lvl;
        end
      end
      base = p[39:12];
    end
    if (leaf_lvl != 0)
    begin
      p              = r.pte[leaf_lvl-1];
      keep_mask      = '1;
      keep_mask      = keep_mask << (9 * (3 - leaf_lvl));
      ref_e.vpn      = r.vpn & keep_mask;
      ref_e.ppn      = {p[39:13], (leaf_lvl == 3) ? p[12] : 1'b0};
      ref_e.flg      = {1'b0, p[63:61], p[12], p[8:0]};
      ref_e.pgs      = {leaf_lvl == 1, leaf_lvl == 2, leaf_lvl == 3};
      ref_e.g        = (leaf_lvl == 3) ? p[6] : p[12];
      ref_e.asid     = ASID;
      ref_e.bank_sel = BANK[4*(3-leaf_lvl) +: 4];
    end
  endtask

  // ====================
  // one walk
  // ====================
  task automatic run_row(input int idx);
    row_t                         r;
    string                        name;
    logic [2:0][`PTW_PADDR_W-1:0] exp_addr;
    int                           n_fetch;
    refill_t                      exp_ref;
    refill_t                      held;
    logic                         req_seen;
    logic                         done;
    int                           wait_n;
    int                           err_before;
    r          = rows[idx];
    name       = names[idx];
    err_before = errors;
    predict_walk(r, exp_addr, n_fetch, exp_ref);
    @(posedge ptw_clk);
    #1;
    tbl_addr = exp_addr;
    tbl_data = r.pte;
    err_lvl  = r.err_lvl;
    satp_ppn = r.satp;
    tbl_load = 1'b1;
    @(posedge ptw_clk);
    #1;
    tbl_load = 1'b0;
    walk_req = '{valid: 1'b1, vpn: r.vpn, bank: BANK, acc: r.acc};
    @(posedge ptw_clk);
    #1;
    walk_req = '0;
    req_seen = 1'b0;
    done     = 1'b0;
    wait_n   = 0;
    held     = '0;
    while (!done)
    begin
      @(negedge ptw_clk);
      if (refill_req)
      begin
        if (!req_seen)
        begin
          held = refill;
          check_refill(name, exp_ref, refill);
        end
        else if (refill !== held)
        begin
          $display("%s: refill entry changed while waiting for grant", name);
          errors++;
        end
        req_seen = 1'b1;
      end
      if (!walk_busy)
      begin
        $display("%s: walk_busy dropped before the walk completed", name);
        errors++;
      end
      if (status.complete)
      begin
        done = 1'b1;
        check_status(name, r.exp_st, status);
        if ((r.exp_st.acc_flt || r.exp_st.pg_flt) && req_seen)
        begin
          $display("%s: refill_req raised on a faulting walk", name);
          errors++;
        end
        else if (!r.exp_st.acc_flt && !r.exp_st.pg_flt && !refill_grant)
        begin
          $display("%s: complete came outside the grant cycle", name);
          errors++;
        end
      end
      @(posedge ptw_clk);
      #1;
      refill_grant = req_seen && !done && (wait_n == int'(r.gnt_dly));
      if (req_seen)
        wait_n++;
    end
    // one cycle later the walker is idle again
    @(negedge ptw_clk);
    check_status(name, '0, status);
    if (walk_busy || refill_req)
    begin
      $display("%s: walker still busy after completion", name);
      errors++;
    end
    if (int'(cap_cnt) != n_fetch)
    begin
      $display("%s: %0d memory reads seen, %0d expected", name, cap_cnt, n_fetch);
      errors++;
    end
    for (int k = 0; k < n_fetch; k++)
      check_addr(name, exp_addr[k], cap_addr[k]);
    if (errors == err_before)
    begin
      passed++;
      $display("test %s: pass", name);
    end
    else
    begin
      failed++;
      $display("test %s: fail, %0d errors", name, errors - err_before);
    end
  endtask

  initial
  begin
    ptw_clk      = 1'b0;
    cpurst_b     = 1'b0;
    walk_req     = '0;
    refill_grant = 1'b0;
    satp_ppn     = '0;
    cur_asid     = ASID;
    tbl_load     = 1'b0;
    tbl_addr     = '0;
    tbl_data     = '0;
    err_lvl      = 2'd0;
    build_table();
    cycle_limit = rows.size() * 40 + 8;
    repeat (8) @(posedge ptw_clk);
    #1;
    cpurst_b = 1'b1;
    foreach (rows[i])
      run_row(i);
    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             rows.size(), passed, failed, errors);
    if (failed == 0 && errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// File: compile.f
+incdir+include
src/ptw_pkg.sv
src/ptw_walk_ctrl.sv
src/ptw_addr_gen.sv
src/ptw_pte_check.sv
src/ptw_refill_build.sv
src/ptw_top.sv
verification/ptw_mem_model.sv
verification/ptw_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the walker testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing -Wno-fatal --top-module ptw_tb -f compile.f -o ptw_sim \
  > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/ptw_sim > sim.log 2>&1
cat sim.log

grep -qx "TEST OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
